//--- run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -f sim.f --top-module ex_stage_tb \
	-Mdir obj_dir -o ex_stage_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/ex_stage_sim > sim.log 2>&1
grep -q "ALL TESTS PASSED" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }

//--- sim.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_if.sv
verilog/ex_dispatch.sv
verilog/ex_int_unit.sv
verilog/ex_mul_unit.sv
verilog/ex_result_merge.sv
verilog/ex_stage.sv
tests/ex_stage_chk.sv
tests/ex_stage_tb.sv

//--- tests/ex_stage_chk.sv
`include "ex_cfg.svh"

module ex_stage_chk (
	input logic                 clock,
	input logic                 arst_n,
	input logic                 issue_req,
	input logic                 issue_ack,
	input logic                 wb_req,
	input logic                 wb_ack,
	input logic [`EX_TAG_W-1:0] wb_tag,
	input logic [4:0]           wb_dest,
	input logic [`EX_XLEN-1:0]  wb_result,
	input logic                 wb_take_branch
);
	timeunit 1ns;
	timeprecision 100ps;

	// ack is registered from the request of the cycle before
	ack_needs_req: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(issue_ack) |-> $past(issue_req)) else $error("issue_ack rose without issue_req");

	//////////////////////////////////////////////////////////////////////
	// writeback side
	//////////////////////////////////////////////////////////////////////

	req_held: assert property (@(posedge clock) disable iff (!arst_n)
		wb_req && !wb_ack |=> wb_req) else $error("wb_req dropped before wb_ack");

	fields_stable: assert property (@(posedge clock) disable iff (!arst_n)
		wb_req && !wb_ack |=> $stable({wb_tag, wb_dest, wb_result, wb_take_branch}))
		else $error("writeback fields changed while wb_req was high");

	// no new request until the old ack is gone
	req_after_ack_low: assert property (@(posedge clock) disable iff (!arst_n)
		!wb_req && wb_ack |=> !wb_req) else $error("wb_req rose while wb_ack was still high");

endmodule

//--- tests/ex_stage_tb.sv
`include "ex_cfg.svh"

module ex_stage_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 100 * (`EX_MUL_CYCLES + 2);

	logic                 clock;
	logic                 arst_n;
	logic                 issue_req;
	logic                 issue_ack;
	ex_pkg::ex_func_e     issue_func;
	ex_pkg::ex_opa_sel_e  issue_opa_sel;
	ex_pkg::ex_opb_sel_e  issue_opb_sel;
	logic [`EX_XLEN-1:0]  issue_rs1;
	logic [`EX_XLEN-1:0]  issue_rs2;
	logic [`EX_XLEN-1:0]  issue_pc;
	logic [`EX_XLEN-1:0]  issue_imm;
	logic [4:0]           issue_dest;
	logic [`EX_TAG_W-1:0] issue_tag;
	logic                 wb_req;
	logic                 wb_ack;
	logic [`EX_TAG_W-1:0] wb_tag;
	logic [4:0]           wb_dest;
	logic [`EX_XLEN-1:0]  wb_result;
	logic                 wb_take_branch;

	// expected result per outstanding tag
	logic [15:0]          exp_valid;
	logic [15:0]          exp_take;
	logic [31:0]          exp_result [16];
	logic [4:0]           exp_dest [16];
	logic [3:0]           next_tag;
	logic [31:0]          lcg_state;
	int                   max_issue_wait;
	int                   errors;

	ex_stage uut (.*);

	bind ex_stage ex_stage_chk chk_0 (.*);

	always #5 clock = ~clock;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// {take_branch, result} from the RV32 rules
	function automatic logic [32:0] predict(ex_pkg::ex_func_e f, logic [31:0] a, logic [31:0] b,
		logic [31:0] rs1, logic [31:0] rs2);
		logic [63:0] sa;
		logic [63:0] za;
		logic [63:0] pu;
		logic [63:0] psu;
		logic [63:0] ps;
		logic [4:0]  sh;
		logic        lt_s;
		logic        lt_u;
		sa = {{32{a[31]}}, a};
		za = {32'd0, a};
		// low 64 bits of a sign-extended product are exact
		pu = za * {32'd0, b};
		psu = sa * {32'd0, b};
		ps = sa * {{32{b[31]}}, b};
		sh = b[4:0];
		lt_s = (rs1 ^ 32'h8000_0000) < (rs2 ^ 32'h8000_0000);
		lt_u = rs1 < rs2;
		case (f)
			ex_pkg::ADD:    return {1'b0, a + b};
			ex_pkg::SUB:    return {1'b0, a - b};
			ex_pkg::AND:    return {1'b0, a & b};
			ex_pkg::OR:     return {1'b0, a | b};
			ex_pkg::XOR:    return {1'b0, a ^ b};
			ex_pkg::SLT:    return {1'b0, 31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
			ex_pkg::SLTU:   return {1'b0, 31'd0, a < b};
			ex_pkg::SLL:    return {1'b0, a << sh};
			ex_pkg::SRL:    return {1'b0, a >> sh};
			ex_pkg::SRA:    return {1'b0, (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh))};
			ex_pkg::MUL:    return {1'b0, pu[31:0]};
			ex_pkg::MULH:   return {1'b0, ps[63:32]};
			ex_pkg::MULHSU: return {1'b0, psu[63:32]};
			ex_pkg::MULHU:  return {1'b0, pu[63:32]};
			ex_pkg::BEQ:    return {rs1 == rs2, a + b};
			ex_pkg::BNE:    return {rs1 != rs2, a + b};
			ex_pkg::BLT:    return {lt_s, a + b};
			ex_pkg::BGE:    return {!lt_s, a + b};
			ex_pkg::BLTU:   return {lt_u, a + b};
			default:        return {!lt_u, a + b};
		endcase
	endfunction

	task automatic stop_on_error(string why);
		errors++;
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("MISMATCH at %0t: %s got %0h expected %0h",
				$time, name, got, exp));
		end
	endtask

	// four-phase issue with the model entry recorded under the tag
	task automatic issue_op(ex_pkg::ex_func_e f, ex_pkg::ex_opa_sel_e asel,
		ex_pkg::ex_opb_sel_e bsel, logic [31:0] rs1, logic [31:0] rs2,
		logic [31:0] pc, logic [31:0] imm);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [3:0]  tag;
		int          waited;
		tag = next_tag;
		next_tag = next_tag + 1'b1;
		r = next_rand();
		a = (asel == ex_pkg::OPA_RS1) ? rs1 : ((asel == ex_pkg::OPA_PC) ? pc : 32'd0);
		b = (bsel == ex_pkg::OPB_IMM) ? imm : rs2;
		if (exp_valid[tag]) stop_on_error("a tag was issued again before its result returned");
		exp_valid[tag] = 1'b1;
		{exp_take[tag], exp_result[tag]} = predict(f, a, b, rs1, rs2);
		exp_dest[tag] = r[4:0];
		issue_func = f;
		issue_opa_sel = asel;
		issue_opb_sel = bsel;
		issue_rs1 = rs1;
		issue_rs2 = rs2;
		issue_pc = pc;
		issue_imm = imm;
		issue_dest = r[4:0];
		issue_tag = tag;
		issue_req = 1'b1;
		waited = 0;
		while (!issue_ack && waited < TIMEOUT) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!issue_ack) stop_on_error("issue_ack never rose for a pending issue request");
		if (waited > max_issue_wait) max_issue_wait = waited;
		issue_req = 1'b0;
		waited = 0;
		while (issue_ack && waited < TIMEOUT) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (issue_ack) stop_on_error("issue_ack stayed high after issue_req fell");
	endtask

	// writeback sink that checks each result by its tag
	task automatic collect(int n, int ack_delay);
		logic [3:0] t;
		int         waited;
		for (int i = 0; i < n; i++) begin
			waited = 0;
			while (!wb_req && waited < TIMEOUT) begin
				@(posedge clock);
				#1;
				waited++;
			end
			if (!wb_req) stop_on_error("an expected writeback request never arrived");
			t = wb_tag;
			if (!exp_valid[t]) stop_on_error("writeback carried a tag that was not outstanding");
			check("wb_result", wb_result, exp_result[t]);
			check("wb_take_branch", wb_take_branch, exp_take[t]);
			check("wb_dest", wb_dest, exp_dest[t]);
			exp_valid[t] = 1'b0;
			repeat (ack_delay) begin
				@(posedge clock);
				#1;
			end
			wb_ack = 1'b1;
			waited = 0;
			while (wb_req && waited < TIMEOUT) begin
				@(posedge clock);
				#1;
				waited++;
			end
			if (wb_req) stop_on_error("wb_req stayed high after wb_ack");
			// slow sink keeps ack high a while after req drops
			repeat (ack_delay) begin
				@(posedge clock);
				#1;
			end
			wb_ack = 1'b0;
		end
	endtask

	// nothing left over once every expected result is in
	task automatic wb_stays_idle(int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clock);
			#1;
			check("wb_req", wb_req, 0);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic idle_after_reset();
		for (int i = 0; i < 10; i++) begin
			check("issue_ack", issue_ack, 0);
			check("wb_req", wb_req, 0);
			@(posedge clock);
			#1;
		end
	endtask

	task automatic alu_op_sweep();
		for (int f = 0; f <= 9; f++)
			for (int a = 0; a < 3; a++)
				for (int b = 0; b < 2; b++)
					fork
						issue_op(ex_pkg::ex_func_e'(f), ex_pkg::ex_opa_sel_e'(a),
							ex_pkg::ex_opb_sel_e'(b), next_rand(), next_rand(),
							next_rand(), next_rand());
						collect(1, 0);
					join
	endtask

	task automatic branch_compares();
		logic [31:0] x [6];
		logic [31:0] y [6];
		// equal, less and greater pairs and pairs where signed and unsigned disagree
		x = '{32'd5, 32'd1, 32'd2, 32'hffff_ffff, 32'd1, 32'h8000_0000};
		y = '{32'd5, 32'd2, 32'd1, 32'd1, 32'hffff_ffff, 32'h7fff_ffff};
		for (int f = 14; f <= 19; f++)
			for (int p = 0; p < 6; p++)
				fork
					issue_op(ex_pkg::ex_func_e'(f), ex_pkg::OPA_PC, ex_pkg::OPB_IMM,
						x[p], y[p], next_rand(), next_rand());
					collect(1, 0);
				join
	endtask

	task automatic multiply_values();
		logic [31:0] v [5];
		for (int f = 10; f <= 13; f++) begin
			v = '{32'd0, 32'hffff_ffff, 32'h8000_0000, next_rand(), next_rand()};
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					fork
						issue_op(ex_pkg::ex_func_e'(f), ex_pkg::OPA_RS1, ex_pkg::OPB_RS2,
							v[i], v[j], 32'd0, 32'd0);
						collect(1, 0);
					join
		end
	endtask

	task automatic overlap_mul_alu();
		fork
			begin
				issue_op(ex_pkg::MULH, ex_pkg::OPA_RS1, ex_pkg::OPB_RS2,
					next_rand(), next_rand(), 32'd0, 32'd0);
				for (int i = 0; i < 5; i++)
					issue_op(ex_pkg::ex_func_e'(i), ex_pkg::OPA_RS1, ex_pkg::OPB_IMM,
						next_rand(), next_rand(), next_rand(), next_rand());
			end
			collect(6, 0);
		join
		wb_stays_idle(2 * (`EX_MUL_CYCLES + 2));
	endtask

	task automatic stall_on_backpressure();
		max_issue_wait = 0;
		fork
			for (int i = 0; i < 12; i++)
				issue_op((i % 5 == 0) ? ex_pkg::MULHSU : ex_pkg::ex_func_e'(i % 10),
					ex_pkg::OPA_RS1, ex_pkg::OPB_RS2, next_rand(), next_rand(),
					next_rand(), next_rand());
			collect(12, 25);
		join
		wb_stays_idle(2 * (`EX_MUL_CYCLES + 2));
		check("issue stalled under back-pressure", max_issue_wait > 10, 1);
	endtask

	initial begin
		clock = 1'b0;
		arst_n = 1'b0;
		issue_req = 1'b0;
		issue_func = ex_pkg::ADD;
		issue_opa_sel = ex_pkg::OPA_RS1;
		issue_opb_sel = ex_pkg::OPB_RS2;
		issue_rs1 = '0;
		issue_rs2 = '0;
		issue_pc = '0;
		issue_imm = '0;
		issue_dest = '0;
		issue_tag = '0;
		wb_ack = 1'b0;
		exp_valid = '0;
		next_tag = '0;
		lcg_state = 32'ha58f5f00;
		max_issue_wait = 0;
		errors = 0;
		repeat (8) @(posedge clock);
		#1;
		arst_n = 1'b1;
		idle_after_reset();
		alu_op_sweep();
		branch_compares();
		multiply_values();
		overlap_mul_alu();
		stall_on_backpressure();
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath and tag widths
`define EX_XLEN 32
`define EX_TAG_W 4

// multiplier bits retired per cycle, 4, 8 or 16
`define EX_MUL_STEP 8

// iteration cycles of the multiplier
`define EX_MUL_CYCLES (`EX_XLEN / `EX_MUL_STEP)

// completed results waiting for writeback
`define EX_RES_DEPTH 4

`endif

//--- verilog/ex_dispatch.sv
`include "ex_cfg.svh"

module ex_dispatch (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  issue_req,
	input  ex_pkg::ex_func_e      issue_func,
	input  ex_pkg::ex_opa_sel_e   issue_opa_sel,
	input  ex_pkg::ex_opb_sel_e   issue_opb_sel,
	input  logic [`EX_XLEN-1:0]   issue_rs1,
	input  logic [`EX_XLEN-1:0]   issue_rs2,
	input  logic [`EX_XLEN-1:0]   issue_pc,
	input  logic [`EX_XLEN-1:0]   issue_imm,
	input  logic [4:0]            issue_dest,
	input  logic [`EX_TAG_W-1:0]  issue_tag,
	output logic                  issue_ack,
	ex_op_if.master               int_op,
	ex_op_if.master               mul_op
);

	typedef enum logic [1:0] {
		IDLE,
		ACKED,
		WAIT_REQ_LOW
	} state_e;

	state_e              state;
	logic [`EX_XLEN-1:0] opa_mux;
	logic [`EX_XLEN-1:0] opb_mux;
	logic                to_mul;
	logic                target_busy;
	logic                launch;

	// operand a mux
	always_comb begin
		case (issue_opa_sel)
			ex_pkg::OPA_RS1: opa_mux = issue_rs1;
			ex_pkg::OPA_PC:  opa_mux = issue_pc;
			default:         opa_mux = '0;
		endcase
	end

	// operand b mux
	assign opb_mux = (issue_opb_sel == ex_pkg::OPB_IMM) ? issue_imm : issue_rs2;

	// route by opcode, only the chosen unit has to be idle
	assign to_mul      = ex_pkg::is_mul_op(issue_func);
	assign target_busy = to_mul ? mul_op.busy : int_op.busy;
	assign launch      = (state == IDLE) && issue_req && !target_busy;

	//////////////////////////////////////////////////////////////////////
	// issue handshake
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state        <= IDLE;
			int_op.start <= 1'b0;
			mul_op.start <= 1'b0;
		end else begin
			int_op.start <= launch && !to_mul;
			mul_op.start <= launch && to_mul;
			case (state)
				IDLE:    if (launch) state <= ACKED;
				default: state <= issue_req ? WAIT_REQ_LOW : IDLE;
			endcase
		end
	end

	assign issue_ack = (state != IDLE);

	// issue fields hold while ack is high, so both units share one bus
	assign int_op.opa  = opa_mux;
	assign int_op.opb  = opb_mux;
	assign int_op.rs1  = issue_rs1;
	assign int_op.rs2  = issue_rs2;
	assign int_op.func = issue_func;
	assign int_op.dest = issue_dest;
	assign int_op.tag  = issue_tag;

	assign mul_op.opa  = opa_mux;
	assign mul_op.opb  = opb_mux;
	assign mul_op.rs1  = issue_rs1;
	assign mul_op.rs2  = issue_rs2;
	assign mul_op.func = issue_func;
	assign mul_op.dest = issue_dest;
	assign mul_op.tag  = issue_tag;

endmodule

//--- verilog/ex_if.sv
`include "ex_cfg.svh"

//////////////////////////////////////////////////////////////////////
// dispatch to one functional unit
//////////////////////////////////////////////////////////////////////

interface ex_op_if;
	logic                 start;
	logic [`EX_XLEN-1:0]  opa;
	logic [`EX_XLEN-1:0]  opb;
	logic [`EX_XLEN-1:0]  rs1;
	logic [`EX_XLEN-1:0]  rs2;
	ex_pkg::ex_func_e     func;
	logic [4:0]           dest;
	logic [`EX_TAG_W-1:0] tag;
	// high from the cycle after start until the result is taken
	logic                 busy;

	modport master (output start, opa, opb, rs1, rs2, func, dest, tag, input busy);
	modport slave (input start, opa, opb, rs1, rs2, func, dest, tag, output busy);
endinterface

//////////////////////////////////////////////////////////////////////
// completion of one functional unit into the merge
//////////////////////////////////////////////////////////////////////

interface ex_res_if;
	// done and data held until take is seen with done
	logic               done;
	ex_pkg::ex_result_t data;
	logic               take;

	modport source (output done, data, input take);
	modport sink (input done, data, output take);
endinterface

//--- verilog/ex_int_unit.sv
`include "ex_cfg.svh"

module ex_int_unit (
	input  logic       clock,
	input  logic       arst_n,
	ex_op_if.slave     op,
	ex_res_if.source   res
);

	logic                done_q;
	logic [`EX_XLEN-1:0] alu_out;
	logic                br_cond;
	logic [4:0]          shamt;
	ex_pkg::ex_result_t  res_q;

	assign shamt = op.opb[4:0];

	// alu, branch target is opa + opb as well
	always_comb begin
		case (op.func)
			ex_pkg::ADD:  alu_out = op.opa + op.opb;
			ex_pkg::SUB:  alu_out = op.opa - op.opb;
			ex_pkg::AND:  alu_out = op.opa & op.opb;
			ex_pkg::OR:   alu_out = op.opa | op.opb;
			ex_pkg::XOR:  alu_out = op.opa ^ op.opb;
			ex_pkg::SLT:  alu_out = {{(`EX_XLEN-1){1'b0}}, $signed(op.opa) < $signed(op.opb)};
			ex_pkg::SLTU: alu_out = {{(`EX_XLEN-1){1'b0}}, op.opa < op.opb};
			ex_pkg::SLL:  alu_out = op.opa << shamt;
			ex_pkg::SRL:  alu_out = op.opa >> shamt;
			ex_pkg::SRA:  alu_out = $unsigned($signed(op.opa) >>> shamt);
			ex_pkg::BEQ,
			ex_pkg::BNE,
			ex_pkg::BLT,
			ex_pkg::BGE,
			ex_pkg::BLTU,
			ex_pkg::BGEU: alu_out = op.opa + op.opb;
			default:      alu_out = '0;
		endcase
	end

	// branch condition on the register values
	always_comb begin
		case (op.func)
			ex_pkg::BEQ:  br_cond = (op.rs1 == op.rs2);
			ex_pkg::BNE:  br_cond = (op.rs1 != op.rs2);
			ex_pkg::BLT:  br_cond = ($signed(op.rs1) < $signed(op.rs2));
			ex_pkg::BGE:  br_cond = ($signed(op.rs1) >= $signed(op.rs2));
			ex_pkg::BLTU: br_cond = (op.rs1 < op.rs2);
			ex_pkg::BGEU: br_cond = (op.rs1 >= op.rs2);
			default:      br_cond = 1'b0;
		endcase
	end

	// one entry, busy for exactly as long as it is full
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			done_q <= 1'b0;
		end else if (op.start) begin
			done_q <= 1'b1;
		end else if (res.take) begin
			done_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (op.start) begin
			res_q <= '{tag: op.tag, dest: op.dest, result: alu_out, take_branch: br_cond};
		end
	end

	assign op.busy  = done_q;
	assign res.done = done_q;
	assign res.data = res_q;

endmodule

//--- verilog/ex_mul_unit.sv
`include "ex_cfg.svh"

module ex_mul_unit (
	input  logic       clock,
	input  logic       arst_n,
	ex_op_if.slave     op,
	ex_res_if.source   res
);

	localparam int PW   = 2 * `EX_XLEN;
	localparam int STEP = `EX_MUL_STEP;
	localparam int CW   = $clog2(`EX_MUL_CYCLES);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		HOLD
	} state_e;

	state_e              state;
	logic [CW-1:0]       cnt;
	logic                last;
	logic                a_signed;
	logic                b_signed;
	logic                neg_a;
	logic                neg_b;
	logic [`EX_XLEN-1:0] a_mag;
	logic [`EX_XLEN-1:0] b_mag;
	logic [PW-1:0]       acc;
	logic [PW-1:0]       mcand;
	logic [`EX_XLEN-1:0] mplier;
	logic [PW-1:0]       acc_next;
	logic [PW-1:0]       prod;
	logic                neg_q;
	logic                hi_q;
	logic [`EX_TAG_W-1:0] tag_q;
	logic [4:0]          dest_q;
	logic [`EX_XLEN-1:0] result_q;

	// magnitudes by signedness, mul keeps the low half so unsigned is fine
	assign a_signed = op.func inside {ex_pkg::MULH, ex_pkg::MULHSU};
	assign b_signed = (op.func == ex_pkg::MULH);
	assign neg_a    = a_signed && op.opa[`EX_XLEN-1];
	assign neg_b    = b_signed && op.opb[`EX_XLEN-1];
	assign a_mag    = neg_a ? -op.opa : op.opa;
	assign b_mag    = neg_b ? -op.opb : op.opb;

	// one digit of the multiplier per cycle
	assign acc_next = acc + mcand * {{(PW-STEP){1'b0}}, mplier[STEP-1:0]};
	assign prod     = neg_q ? -acc_next : acc_next;
	assign last     = (cnt == CW'(`EX_MUL_CYCLES - 1));

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				IDLE: begin
					cnt <= '0;
					if (op.start) state <= RUN;
				end
				RUN: begin
					cnt <= cnt + 1'b1;
					if (last) state <= HOLD;
				end
				default: if (res.take) state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE && op.start) begin
			acc    <= '0;
			mcand  <= {{`EX_XLEN{1'b0}}, a_mag};
			mplier <= b_mag;
			neg_q  <= neg_a ^ neg_b;
			hi_q   <= (op.func != ex_pkg::MUL);
			tag_q  <= op.tag;
			dest_q <= op.dest;
		end else if (state == RUN) begin
			acc    <= acc_next;
			mcand  <= mcand << STEP;
			mplier <= mplier >> STEP;
			if (last) result_q <= hi_q ? prod[PW-1:`EX_XLEN] : prod[`EX_XLEN-1:0];
		end
	end

	assign op.busy  = (state != IDLE);
	assign res.done = (state == HOLD);
	assign res.data = '{tag: tag_q, dest: dest_q, result: result_q, take_branch: 1'b0};

endmodule

//--- verilog/ex_pkg.sv
`include "ex_cfg.svh"

package ex_pkg;

	// function opcodes of the execute stage
	typedef enum logic [4:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		SLTU,
		SLL,
		SRL,
		SRA,
		MUL,
		MULH,
		MULHSU,
		MULHU,
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU
	} ex_func_e;

	// operand a source
	typedef enum logic [1:0] {
		OPA_RS1,
		OPA_PC,
		OPA_ZERO
	} ex_opa_sel_e;

	// operand b source
	typedef enum logic {
		OPB_RS2,
		OPB_IMM
	} ex_opb_sel_e;

	// one completed operation
	typedef struct packed {
		logic [`EX_TAG_W-1:0] tag;
		logic [4:0]           dest;
		logic [`EX_XLEN-1:0]  result;
		logic                 take_branch;
	} ex_result_t;

	// ops served by the iterative multiplier
	function automatic logic is_mul_op(ex_func_e func);
		return func inside {MUL, MULH, MULHSU, MULHU};
	endfunction

endpackage

//--- verilog/ex_result_merge.sv
`include "ex_cfg.svh"

module ex_result_merge (
	input  logic                 clock,
	input  logic                 arst_n,
	ex_res_if.sink               int_res,
	ex_res_if.sink               mul_res,
	output logic                 wb_req,
	input  logic                 wb_ack,
	output logic [`EX_TAG_W-1:0] wb_tag,
	output logic [4:0]           wb_dest,
	output logic [`EX_XLEN-1:0]  wb_result,
	output logic                 wb_take_branch
);

	localparam int DEPTH = `EX_RES_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT_ACK_LOW
	} state_e;

	state_e               state;
	ex_pkg::ex_result_t   q_mem [DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [PTR_W:0]       count;
	logic                 room;
	logic                 push;
	logic                 pop;
	ex_pkg::ex_result_t   head;

	// multiplier first, int unit waits with done high
	assign room         = (count != (PTR_W+1)'(DEPTH));
	assign mul_res.take = mul_res.done && room;
	assign int_res.take = int_res.done && room && !mul_res.done;
	assign push         = mul_res.take || int_res.take;
	assign pop          = (state == REQ) && wb_ack;

	always_ff @(posedge clock) begin
		if (push) q_mem[wr_ptr] <= mul_res.take ? mul_res.data : int_res.data;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			state  <= IDLE;
		end else begin
			if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + push - pop;
			// writeback handshake from the queue head
			case (state)
				IDLE:    if (count != '0 || push) state <= REQ;
				REQ:     if (wb_ack) state <= WAIT_ACK_LOW;
				default: if (!wb_ack) state <= IDLE;
			endcase
		end
	end

	assign head           = q_mem[rd_ptr];
	assign wb_req         = (state == REQ);
	assign wb_tag         = head.tag;
	assign wb_dest        = head.dest;
	assign wb_result      = head.result;
	assign wb_take_branch = head.take_branch;

endmodule

//--- verilog/ex_stage.sv
`include "ex_cfg.svh"

module ex_stage (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  issue_req,
	input  ex_pkg::ex_func_e      issue_func,
	input  ex_pkg::ex_opa_sel_e   issue_opa_sel,
	input  ex_pkg::ex_opb_sel_e   issue_opb_sel,
	input  logic [`EX_XLEN-1:0]   issue_rs1,
	input  logic [`EX_XLEN-1:0]   issue_rs2,
	input  logic [`EX_XLEN-1:0]   issue_pc,
	input  logic [`EX_XLEN-1:0]   issue_imm,
	input  logic [4:0]            issue_dest,
	input  logic [`EX_TAG_W-1:0]  issue_tag,
	output logic                  issue_ack,
	output logic                  wb_req,
	input  logic                  wb_ack,
	output logic [`EX_TAG_W-1:0]  wb_tag,
	output logic [4:0]            wb_dest,
	output logic [`EX_XLEN-1:0]   wb_result,
	output logic                  wb_take_branch
);

	// one op link and one completion link per unit
	ex_op_if  int_op ();
	ex_op_if  mul_op ();
	ex_res_if int_res ();
	ex_res_if mul_res ();

	ex_dispatch dispatch_0 (
		.clock         (clock),
		.arst_n        (arst_n),
		.issue_req     (issue_req),
		.issue_func    (issue_func),
		.issue_opa_sel (issue_opa_sel),
		.issue_opb_sel (issue_opb_sel),
		.issue_rs1     (issue_rs1),
		.issue_rs2     (issue_rs2),
		.issue_pc      (issue_pc),
		.issue_imm     (issue_imm),
		.issue_dest    (issue_dest),
		.issue_tag     (issue_tag),
		.issue_ack     (issue_ack),
		.int_op        (int_op.master),
		.mul_op        (mul_op.master)
	);

	ex_int_unit int_unit_0 (.clock(clock), .arst_n(arst_n), .op(int_op.slave), .res(int_res.source));

	ex_mul_unit mul_unit_0 (.clock(clock), .arst_n(arst_n), .op(mul_op.slave), .res(mul_res.source));

	ex_result_merge merge_0 (
		.clock          (clock),
		.arst_n         (arst_n),
		.int_res        (int_res.sink),
		.mul_res        (mul_res.sink),
		.wb_req         (wb_req),
		.wb_ack         (wb_ack),
		.wb_tag         (wb_tag),
		.wb_dest        (wb_dest),
		.wb_result      (wb_result),
		.wb_take_branch (wb_take_branch)
	);

endmodule
